// ==== Bender.yml ====
package:
  name: main_cpu_board

sources:
  - hw/main_bus_pkg.sv
  - hw/main_addr_decoder.sv
  - hw/main_bus_ctrl.sv
  - hw/main_irq_ctrl.sv
  - hw/main_io_regs.sv
  - hw/main_cpu_board.sv
  - target: test
    files:
      - tests/main_cpu_board_checker.sv
      - tests/main_cpu_board_tb.sv

// ==== hw/main_addr_decoder.sv ====
`timescale 1ns/1ps

module main_addr_decoder #(
    parameter int ROM_BANKS = 6
) (
    input  main_bus_pkg::addr_t        addr,
    input  logic                       rnw,
    output main_bus_pkg::main_target_e target
);

    logic [1:0] region;    // cpu a[21:20]
    logic [2:0] vid_sel;   // cpu a[15:13]
    logic [2:0] ram_sel;   // cpu a[16:14]
    logic [2:0] reg_sel;   // cpu a[3:1]
    logic       io_group;  // 0x30c0xx

    assign region   = addr[20:19];
    assign vid_sel  = addr[14:12];
    assign ram_sel  = addr[15:13];
    assign reg_sel  = addr[2:0];
    assign io_group = addr[12:4] == 9'd0;

    always_comb begin
        target = main_bus_pkg::tgt_none;
        if (addr[22:21] == 2'b00) begin  // nothing above 0x3fffff
            case (region)
                2'd0: begin
                    // program rom, one bank per 64 KiB
                    if (rnw && int'(addr[18:15]) < ROM_BANKS)
                        target = main_bus_pkg::tgt_rom;
                end
                2'd2: begin
                    if (addr[18:15] == 4'h4) begin  // 0x24xxxx
                        case (vid_sel)
                            3'd0: target = main_bus_pkg::tgt_fmode;   // cfg regs
                            3'd1: target = main_bus_pkg::tgt_fsft;    // row/col scroll
                            3'd2: target = main_bus_pkg::tgt_fmap;
                            3'd3: target = main_bus_pkg::tgt_bmode;
                            3'd4: target = main_bus_pkg::tgt_bsft;
                            3'd5: target = main_bus_pkg::tgt_bmap;
                            3'd6: target = main_bus_pkg::tgt_nexrm0;  // second board
                            default: ;
                        endcase
                    end
                end
                2'd3: begin
                    if (addr[18:16] == 3'd0) begin  // 0x30xxxx to 0x31xxxx
                        case (ram_sel)
                            3'd3: begin
                                if (io_group && rnw && !addr[3]) begin
                                    case (reg_sel)
                                        3'd0: target = main_bus_pkg::tgt_cab0;
                                        3'd1: target = main_bus_pkg::tgt_cab1;
                                        3'd2: target = main_bus_pkg::tgt_dip;
                                        3'd4: target = main_bus_pkg::tgt_sec_rd;
                                        default: ;
                                    endcase
                                end else if (io_group && !rnw && addr[3]) begin
                                    case (reg_sel)
                                        3'd0: target = main_bus_pkg::tgt_prisel;
                                        3'd2: target = main_bus_pkg::tgt_snd;
                                        3'd4: target = main_bus_pkg::tgt_vint_clr;
                                        default: ;
                                    endcase
                                end
                            end
                            3'd4: target = main_bus_pkg::tgt_pal0;    // 0x310000
                            3'd5: target = main_bus_pkg::tgt_pal1;    // 0x314000
                            3'd6: target = main_bus_pkg::tgt_sysram;  // 0x318000
                            3'd7: target = main_bus_pkg::tgt_mix;     // 0x31c000
                            default: ;
                        endcase
                    end
                end
                default: ;  // eeprom slot is not fitted
            endcase
        end
    end

endmodule

// ==== hw/main_bus_ctrl.sv ====
`timescale 1ns/1ps

module main_bus_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // bus master
    input  logic                       req,
    input  main_bus_pkg::addr_t        addr,
    input  logic                       rnw,
    input  main_bus_pkg::data_t        wdata,
    output logic                       ack,
    output main_bus_pkg::data_t        rdata,
    // decoder
    output main_bus_pkg::addr_t        dec_addr,
    output logic                       dec_rnw,
    input  main_bus_pkg::main_target_e target,
    // external chip selects
    output logic                       fmode_cs,
    output logic                       fsft_cs,
    output logic                       fmap_cs,
    output logic                       bmode_cs,
    output logic                       bsft_cs,
    output logic                       bmap_cs,
    output logic                       nexrm0_cs,
    output logic [1:0]                 pal_cs,
    output logic                       ram_cs,
    output logic                       vram_cs,
    input  main_bus_pkg::data_t        ram_data,
    input  logic                       ram_ok,
    // io registers
    input  main_bus_pkg::data_t        io_rdata,
    output logic                       vint_clr,
    output logic                       sec_clr,
    output logic                       prisel_we,
    output logic                       snd_we,
    output main_bus_pkg::data_t        io_wdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_access,
        st_wait_mem,
        st_done,
        st_release
    } state_e;

    state_e     state;
    logic [1:0] lat_cnt;    // internal latency count
    logic       ext;        // target answers through ram_ok
    logic       mem_phase;  // chip select window
    logic       first;      // first cycle after req sampled
    logic       int_last;
    logic       ext_last;
    logic       start;

    assign ext = target inside {
        main_bus_pkg::tgt_rom,   main_bus_pkg::tgt_fmode, main_bus_pkg::tgt_fsft,
        main_bus_pkg::tgt_fmap,  main_bus_pkg::tgt_bmode, main_bus_pkg::tgt_bsft,
        main_bus_pkg::tgt_bmap,  main_bus_pkg::tgt_nexrm0, main_bus_pkg::tgt_pal0,
        main_bus_pkg::tgt_pal1,  main_bus_pkg::tgt_sysram, main_bus_pkg::tgt_mix
    };

    assign start     = (state == st_idle || state == st_release) && req;
    assign mem_phase = ext && (state == st_access || state == st_wait_mem);
    assign first     = state == st_access && lat_cnt == 2'd0;
    assign int_last  = state == st_access && !ext
                       && lat_cnt == 2'(main_bus_pkg::INT_LATENCY - 1);
    assign ext_last  = mem_phase && ram_ok;

    assign fmode_cs  = mem_phase && target == main_bus_pkg::tgt_fmode;
    assign fsft_cs   = mem_phase && target == main_bus_pkg::tgt_fsft;
    assign fmap_cs   = mem_phase && target == main_bus_pkg::tgt_fmap;
    assign bmode_cs  = mem_phase && target == main_bus_pkg::tgt_bmode;
    assign bsft_cs   = mem_phase && target == main_bus_pkg::tgt_bsft;
    assign bmap_cs   = mem_phase && target == main_bus_pkg::tgt_bmap;
    assign nexrm0_cs = mem_phase && target == main_bus_pkg::tgt_nexrm0;
    assign pal_cs[0] = mem_phase && target == main_bus_pkg::tgt_pal0;
    assign pal_cs[1] = mem_phase && target == main_bus_pkg::tgt_pal1;
    assign ram_cs    = mem_phase && (target == main_bus_pkg::tgt_sysram
                                     || target == main_bus_pkg::tgt_rom);
    assign vram_cs   = mem_phase && target == main_bus_pkg::tgt_mix;

    // one pulse per bus cycle
    assign vint_clr  = first && target == main_bus_pkg::tgt_vint_clr;
    assign sec_clr   = first && target == main_bus_pkg::tgt_sec_rd;  // read clears
    assign prisel_we = first && target == main_bus_pkg::tgt_prisel;
    assign snd_we    = first && target == main_bus_pkg::tgt_snd;

    assign ack = state == st_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            lat_cnt <= 2'd0;
        end else begin
            case (state)
                st_idle, st_release: begin
                    lat_cnt <= 2'd0;
                    state   <= req ? st_access : st_idle;
                end
                st_access, st_wait_mem: begin
                    if (ext_last || int_last)
                        state <= st_done;
                    else if (ext)
                        state <= st_wait_mem;  // no limit on memory wait
                    else
                        lat_cnt <= lat_cnt + 2'd1;
                end
                st_done: begin
                    if (!req)
                        state <= st_release;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dec_addr <= addr;
            dec_rnw  <= rnw;
            io_wdata <= wdata;
        end
        if (ext_last)
            rdata <= ram_data;
        else if (int_last)
            rdata <= target == main_bus_pkg::tgt_none ? '1 : io_rdata;
    end

endmodule

// ==== hw/main_bus_pkg.sv ====
package main_bus_pkg;

    typedef logic [22:0] addr_t;  // cpu a[23:1]
    typedef logic [15:0] data_t;
    typedef logic [2:0]  ipl_t;   // active low, 7 is idle

    typedef enum logic [4:0] {
        tgt_none,
        tgt_rom,
        // display window 0x24xxxx
        tgt_fmode,
        tgt_fsft,
        tgt_fmap,
        tgt_bmode,
        tgt_bsft,
        tgt_bmap,
        tgt_nexrm0,
        // ram/io region
        tgt_pal0,
        tgt_pal1,
        tgt_sysram,
        tgt_mix,
        // 0x30c000 read ports
        tgt_cab0,
        tgt_cab1,
        tgt_dip,
        tgt_sec_rd,
        // 0x30c010 write registers
        tgt_prisel,
        tgt_snd,
        tgt_vint_clr
    } main_target_e;

    localparam int INT_LATENCY = 2;  // req sample to ack, internal targets

    localparam int VINT_LEVEL = 6;
    localparam int SEC_LEVEL  = 5;
    localparam int NEX_LEVEL  = 4;

endpackage

// ==== hw/main_cpu_board.sv ====
`timescale 1ns/1ps

module main_cpu_board #(
    parameter int ROM_BANKS = 6
) (
    input  logic                clk,
    input  logic                rst,
    // bus master port
    input  logic                req,
    input  main_bus_pkg::addr_t addr,
    input  logic                rnw,
    input  main_bus_pkg::data_t wdata,
    output logic                ack,
    output main_bus_pkg::data_t rdata,
    // external memories and video chips
    output logic                fmode_cs,
    output logic                fsft_cs,
    output logic                fmap_cs,
    output logic                bmode_cs,
    output logic                bsft_cs,
    output logic                bmap_cs,
    output logic                nexrm0_cs,
    output logic [1:0]          pal_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    input  main_bus_pkg::data_t ram_data,
    input  logic                ram_ok,
    // interrupts
    input  logic                lvbl,
    input  logic                sec2,
    input  logic                nex_irq,
    output main_bus_pkg::ipl_t  ipl,
    // cabinet
    input  logic [7:0]          joystick1,
    input  logic [7:0]          joystick2,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    // board registers
    output logic [2:0]          prisel,
    output logic [7:0]          snd_latch,
    output logic                snd_irq
);

    main_bus_pkg::addr_t        dec_addr;
    logic                       dec_rnw;
    main_bus_pkg::main_target_e target;
    main_bus_pkg::data_t        io_rdata;
    main_bus_pkg::data_t        io_wdata;
    logic                       vint_clr;
    logic                       sec_clr;
    logic                       prisel_we;
    logic                       snd_we;
    logic                       lvbl_q;

    main_addr_decoder #(
        .ROM_BANKS (ROM_BANKS)
    ) u_decoder (
        .addr   (dec_addr),
        .rnw    (dec_rnw),
        .target (target)
    );

    main_bus_ctrl u_bus (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .rnw       (rnw),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .dec_addr  (dec_addr),
        .dec_rnw   (dec_rnw),
        .target    (target),
        .fmode_cs  (fmode_cs),
        .fsft_cs   (fsft_cs),
        .fmap_cs   (fmap_cs),
        .bmode_cs  (bmode_cs),
        .bsft_cs   (bsft_cs),
        .bmap_cs   (bmap_cs),
        .nexrm0_cs (nexrm0_cs),
        .pal_cs    (pal_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .io_rdata  (io_rdata),
        .vint_clr  (vint_clr),
        .sec_clr   (sec_clr),
        .prisel_we (prisel_we),
        .snd_we    (snd_we),
        .io_wdata  (io_wdata)
    );

    main_irq_ctrl u_irq (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (lvbl),
        .sec2     (sec2),
        .nex_irq  (nex_irq),
        .vint_clr (vint_clr),
        .sec_clr  (sec_clr),
        .ipl      (ipl),
        .lvbl_q   (lvbl_q)
    );

    main_io_regs u_io (
        .clk          (clk),
        .rst          (rst),
        .target       (target),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .lvbl_q       (lvbl_q),
        .io_wdata     (io_wdata),
        .prisel_we    (prisel_we),
        .snd_we       (snd_we),
        .io_rdata     (io_rdata),
        .prisel       (prisel),
        .snd_latch    (snd_latch),
        .snd_irq      (snd_irq)
    );

endmodule

// ==== hw/main_io_regs.sv ====
`timescale 1ns/1ps

module main_io_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  main_bus_pkg::main_target_e target,
    // cabinet
    input  logic [7:0]                 joystick1,
    input  logic [7:0]                 joystick2,
    input  logic [1:0]                 start_button,
    input  logic [1:0]                 coin_input,
    input  logic                       service,
    input  logic [7:0]                 dipsw_a,
    input  logic [7:0]                 dipsw_b,
    input  logic                       lvbl_q,
    // bus side
    input  main_bus_pkg::data_t        io_wdata,
    input  logic                       prisel_we,
    input  logic                       snd_we,
    output main_bus_pkg::data_t        io_rdata,
    // board registers
    output logic [2:0]                 prisel,
    output logic [7:0]                 snd_latch,
    output logic                       snd_irq
);

    // read mux, valid one cycle after target settles
    always_ff @(posedge clk) begin
        case (target)
            main_bus_pkg::tgt_cab0:
                io_rdata <= {joystick2, joystick1};
            main_bus_pkg::tgt_cab1:
                io_rdata <= {8'hff, ~lvbl_q, service, coin_input, start_button, 2'b11};
            main_bus_pkg::tgt_dip:
                io_rdata <= {dipsw_b, dipsw_a};
            default:
                io_rdata <= '1;  // security chip reads back ones
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prisel    <= 3'd0;
            snd_latch <= 8'd0;
            snd_irq   <= 1'b0;
        end else begin
            if (prisel_we)
                prisel <= io_wdata[2:0];  // layer priority
            if (snd_we) begin
                snd_latch <= io_wdata[7:0];
                snd_irq   <= ~snd_irq;    // sound cpu sees a toggle
            end
        end
    end

endmodule

// ==== hw/main_irq_ctrl.sv ====
`timescale 1ns/1ps

module main_irq_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               lvbl,
    input  logic               sec2,
    input  logic               nex_irq,   // level from second board
    input  logic               vint_clr,
    input  logic               sec_clr,
    output main_bus_pkg::ipl_t ipl,
    output logic               lvbl_q
);

    logic sec2_q;
    logic vint_pend;
    logic sec_pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_q    <= 1'b0;
            sec2_q    <= 1'b1;  // no false rising edge after reset
            vint_pend <= 1'b0;
            sec_pend  <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            sec2_q <= sec2;

            if (vint_clr)
                vint_pend <= 1'b0;
            else if (lvbl_q && !lvbl)  // start of vertical blank
                vint_pend <= 1'b1;

            if (sec_clr)
                sec_pend <= 1'b0;
            else if (!sec2_q && sec2)
                sec_pend <= 1'b1;
        end
    end

    always_comb begin
        if (vint_pend)
            ipl = main_bus_pkg::ipl_t'(main_bus_pkg::VINT_LEVEL);
        else if (sec_pend)
            ipl = main_bus_pkg::ipl_t'(main_bus_pkg::SEC_LEVEL);
        else if (nex_irq)
            ipl = main_bus_pkg::ipl_t'(main_bus_pkg::NEX_LEVEL);
        else
            ipl = '1;
    end

endmodule

// ==== main_cpu_board.f ====
hw/main_bus_pkg.sv
hw/main_addr_decoder.sv
hw/main_bus_ctrl.sv
hw/main_irq_ctrl.sv
hw/main_io_regs.sv
hw/main_cpu_board.sv
tests/main_cpu_board_checker.sv
tests/main_cpu_board_tb.sv

// ==== tests/main_cpu_board_checker.sv ====
`timescale 1ns/1ps

module main_cpu_board_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       req,
    input logic                       ack,
    input main_bus_pkg::data_t        rdata,
    input main_bus_pkg::main_target_e target,
    input logic [10:0]                cs_vec,
    input main_bus_pkg::ipl_t         ipl,
    input logic                       vint_pend,
    input logic                       sec_pend,
    input logic                       nex_irq
);

    int                 fail_count = 0;
    logic               int_tgt;   // answered inside the board
    main_bus_pkg::ipl_t ipl_exp;

    assign int_tgt = target inside {
        main_bus_pkg::tgt_none,   main_bus_pkg::tgt_cab0,   main_bus_pkg::tgt_cab1,
        main_bus_pkg::tgt_dip,    main_bus_pkg::tgt_sec_rd, main_bus_pkg::tgt_prisel,
        main_bus_pkg::tgt_snd,    main_bus_pkg::tgt_vint_clr
    };

    // vblank over security over second board
    assign ipl_exp = vint_pend ? 3'd6 : sec_pend ? 3'd5 : nex_irq ? 3'd4 : 3'd7;

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    ack_release: assert property (@(posedge clk) disable iff (rst)
        ack && !req |=> !ack)
        else begin
            $error("ack stayed high after req fell");
            fail_count++;
        end

    int_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(req) ##1 int_tgt |=> !ack ##1 ack)
        else begin
            $error("internal cycle did not ack in 2 cycles");
            fail_count++;
        end

    one_cs: assert property (@(posedge clk) disable iff (rst)
        $onehot0(cs_vec))
        else begin
            $error("more than one chip select high");
            fail_count++;
        end

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        ack && req |=> ack && $stable(rdata))
        else begin
            $error("ack or rdata moved while req held");
            fail_count++;
        end

    ipl_rule: assert property (@(posedge clk) disable iff (rst)
        ipl == ipl_exp)
        else begin
            $error("ipl does not match pending sources");
            fail_count++;
        end

endmodule

bind main_cpu_board main_cpu_board_checker chk (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .rdata     (rdata),
    .target    (target),
    .cs_vec    ({fmode_cs, fsft_cs, fmap_cs, bmode_cs, bsft_cs, bmap_cs,
                 nexrm0_cs, pal_cs, ram_cs, vram_cs}),
    .ipl       (ipl),
    .vint_pend (u_irq.vint_pend),
    .sec_pend  (u_irq.sec_pend),
    .nex_irq   (nex_irq)
);

// ==== tests/main_cpu_board_tb.sv ====
`timescale 1ns/1ps

module main_cpu_board_tb;

    logic                clk;
    logic                rst;
    logic                req;
    main_bus_pkg::addr_t addr;
    logic                rnw;
    main_bus_pkg::data_t wdata;
    logic                ack;
    main_bus_pkg::data_t rdata;
    logic                fmode_cs;
    logic                fsft_cs;
    logic                fmap_cs;
    logic                bmode_cs;
    logic                bsft_cs;
    logic                bmap_cs;
    logic                nexrm0_cs;
    logic [1:0]          pal_cs;
    logic                ram_cs;
    logic                vram_cs;
    main_bus_pkg::data_t ram_data;
    logic                ram_ok;
    logic                lvbl;
    logic                sec2;
    logic                nex_irq;
    main_bus_pkg::ipl_t  ipl;
    logic [7:0]          joystick1;
    logic [7:0]          joystick2;
    logic [1:0]          start_button;
    logic [1:0]          coin_input;
    logic                service;
    logic [7:0]          dipsw_a;
    logic [7:0]          dipsw_b;
    logic [2:0]          prisel;
    logic [7:0]          snd_latch;
    logic                snd_irq;

    logic [10:0] cs_vec;
    logic [10:0] cs_seen;   // chip selects seen during the current cycle
    int          mem_wait;
    bit          mem_busy;
    int          errors;
    int          timeouts;
    int          tests;
    int          bad_tests;
    int          mark;

    assign cs_vec = {fmode_cs, fsft_cs, fmap_cs, bmode_cs, bsft_cs, bmap_cs,
                     nexrm0_cs, pal_cs, ram_cs, vram_cs};

    main_cpu_board #(.ROM_BANKS(6)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic main_bus_pkg::data_t mem_word(input main_bus_pkg::addr_t a);
        return a[15:0] ^ {a[22:16], 9'h0} ^ 16'h5a3c;
    endfunction

    // memory answers after 0 to 5 cycles
    always @(negedge clk) begin
        if (cs_vec != 0) begin
            cs_seen = cs_seen | cs_vec;
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $urandom_range(5, 0);
            end
            if (mem_wait == 0) begin
                ram_ok   <= 1'b1;
                ram_data <= mem_word(addr);
            end else begin
                mem_wait--;
                ram_ok <= 1'b0;
            end
        end else begin
            mem_busy = 1'b0;
            ram_ok   <= 1'b0;
        end
    end

    task automatic check_word(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s gave %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_cycle(input main_bus_pkg::addr_t a, input logic r,
                             input main_bus_pkg::data_t d, input int hold,
                             output main_bus_pkg::data_t q);
        int n;
        @(negedge clk);
        addr    = a;
        rnw     = r;
        wdata   = d;
        req     = 1'b1;
        cs_seen = '0;
        n = 0;
        while (!ack && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("No ack arrived for the bus cycle at word address %h", a);
            timeouts++;
        end
        q = rdata;
        repeat (hold) begin
            @(negedge clk);
            check_word("held rdata", rdata, q);
            check_word("held ack", 16'(ack), 16'd1);
        end
        req = 1'b0;
        @(negedge clk);
        check_word("ack after release", 16'(ack), 16'd0);
        n = 0;
        while (ack && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("ack never dropped after req was released");
            timeouts++;
        end
    endtask

    task automatic wait_ipl(input logic [2:0] exp, input string what);
        int n;
        n = 0;
        while (ipl !== exp && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_word(what, 16'(ipl), 16'(exp));
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors + timeouts == mark) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors + timeouts - mark);
            bad_tests++;
        end
        mark = errors + timeouts;
    endtask

    initial begin
        #2ms;
        $display("Simulation watchdog expired");
        $display("Test failed");
        $finish;
    end

    initial begin
        main_bus_pkg::data_t q;
        main_bus_pkg::data_t d;
        main_bus_pkg::addr_t ext_addr [11];
        int                  ext_bit [11];
        void'($urandom(32'h4e56_6170));
        rst = 1'b1;
        {req, rnw, ram_ok, sec2, nex_irq} = '0;
        service = 1'b1;  // differs from the inverted lvbl bit beside it
        addr = '0;
        wdata = '0;
        ram_data = '0;
        lvbl = 1'b1;
        {joystick1, joystick2, dipsw_a, dipsw_b} = $urandom;
        start_button = $urandom;
        coin_input = $urandom;
        {errors, timeouts, tests, bad_tests, mark, mem_wait} = '0;
        mem_busy = 1'b0;
        cs_seen = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        bus_cycle(23'h186000, 1'b1, 16'h0, 0, q);
        check_word("cab0", q, {joystick2, joystick1});
        bus_cycle(23'h186001, 1'b1, 16'h0, 0, q);
        check_word("cab1", q, {8'hff, ~lvbl, service, coin_input, start_button, 2'b11});
        bus_cycle(23'h186002, 1'b1, 16'h0, 0, q);
        check_word("dip", q, {dipsw_b, dipsw_a});
        end_test("cabinet and dip ports");

        for (int k = 0; k < 7; k++) begin
            ext_addr[k] = 23'h120000 + k * 23'h1000 + 23'($urandom_range(23'h7ff, 0));
            ext_bit[k]  = 10 - k;
        end
        ext_addr[7]  = 23'h188010;  // palette 0
        ext_bit[7]   = 2;
        ext_addr[8]  = 23'h18a020;
        ext_bit[8]   = 3;
        ext_addr[9]  = 23'h18c100;  // sysram
        ext_bit[9]   = 1;
        ext_addr[10] = 23'h18e044;  // mix
        ext_bit[10]  = 0;
        for (int k = 0; k < 11; k++) begin
            bus_cycle(ext_addr[k], 1'b1, 16'h0, 0, q);
            check_word("external chip select", 16'(cs_seen), 16'(11'd1 << ext_bit[k]));
            check_word("external read", q, mem_word(ext_addr[k]));
        end
        bus_cycle(23'h028123, 1'b1, 16'h0, 0, q);  // rom bank 5
        check_word("rom chip select", 16'(cs_seen), 16'h0002);
        check_word("rom read", q, mem_word(23'h028123));
        end_test("external targets");

        bus_cycle(23'h000100, 1'b0, 16'h1234, 0, q);
        check_word("rom write chip select", 16'(cs_seen), 16'h0);
        bus_cycle(23'h030000, 1'b1, 16'h0, 0, q);
        check_word("rom past banks", q, 16'hffff);
        check_word("rom past banks chip select", 16'(cs_seen), 16'h0);
        bus_cycle(23'h100000, 1'b1, 16'h0, 0, q);
        check_word("unused address", q, 16'hffff);
        check_word("unused chip select", 16'(cs_seen), 16'h0);
        end_test("unmapped accesses");

        @(negedge clk);
        lvbl = 1'b0;
        wait_ipl(3'd6, "vblank ipl");
        sec2 = 1'b1;
        repeat (3) @(negedge clk);
        check_word("vblank over security", 16'(ipl), 16'd6);
        bus_cycle(23'h18600c, 1'b0, 16'h0, 0, q);
        wait_ipl(3'd5, "security ipl");
        nex_irq = 1'b1;
        bus_cycle(23'h186004, 1'b1, 16'h0, 0, q);
        check_word("security read", q, 16'hffff);
        wait_ipl(3'd4, "second board ipl");
        nex_irq = 1'b0;
        wait_ipl(3'd7, "idle ipl");
        end_test("interrupt priority");

        d = $urandom;
        bus_cycle(23'h186008, 1'b0, d, 0, q);
        check_word("prisel", 16'(prisel), 16'(d[2:0]));
        for (int k = 0; k < 2; k++) begin
            d = $urandom;
            bus_cycle(23'h18600a, 1'b0, d, 0, q);
            check_word("sound latch", 16'(snd_latch), 16'(d[7:0]));
            check_word("sound irq", 16'(snd_irq), 16'(k == 0));
        end
        end_test("write registers");

        bus_cycle(23'h186002, 1'b1, 16'h0, 5, q);
        check_word("held dip read", q, {dipsw_b, dipsw_a});
        bus_cycle(23'h18c200, 1'b1, 16'h0, 4, q);
        check_word("held sysram read", q, mem_word(23'h18c200));
        end_test("back-pressure");

        errors = errors + UUT.chk.fail_count;
        $display("tests %0d, tests with errors %0d, errors %0d, timeouts %0d",
                 tests, bad_tests, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
